/* rtl/memRr_params.svh */
// ==================================================
// Sizing macros for the memory register-read block.
// Include wherever register count, data width or
// active-list pointer width is needed.
// ==================================================

`ifndef MEMRR_PARAMS_SVH
`define MEMRR_PARAMS_SVH

// Physical register count
`define MEMRR_NUM_PREG 32

// Data path and PC width
`define MEMRR_DATA_W 32

// Active-list pointer width
`define MEMRR_AL_W 5

`endif

/* rtl/MemRrPkg.sv */
// ==================================================
// Shared types for the memory register-read block:
// operands, memory ops, lane payloads, recovery
// info, read port structs and the flush test.
// ==================================================

`include "memRr_params.svh"

package MemRrPkg;

    // Operand source
    typedef enum logic [1:0] {
        OotReg = 2'd0,
        OotImm = 2'd1,
        OotPc  = 2'd2
    } OperandType;

    typedef logic [$clog2(`MEMRR_NUM_PREG)-1:0] PRegNum;
    typedef logic [`MEMRR_AL_W-1:0] ActiveListPtr;
    typedef logic [`MEMRR_DATA_W-1:0] DataWord;

    typedef struct packed {
        DataWord data;
        logic    ready;
    } Operand;

    // Fields carried by every memory op
    typedef struct packed {
        PRegNum       srcA;
        PRegNum       srcB;
        OperandType   typeA;
        OperandType   typeB;
        DataWord      imm;
        DataWord      pc;
        ActiveListPtr alPtr;
        logic [3:0]   tag;
    } MemOpCommon;

    typedef struct packed {
        logic [1:0] size;
        logic       signExt;
    } LoadPayload;

    typedef struct packed {
        logic [1:0] size;
        logic [3:0] byteMask;
    } StorePayload;

    typedef struct packed {
        logic         flushAll;
        logic         flushRange;
        ActiveListPtr head;
        ActiveListPtr tail;
    } RecoveryInfo;

    typedef struct packed {
        logic   valid;
        PRegNum srcA;
        PRegNum srcB;
    } ReadReq;

    typedef struct packed {
        Operand a;
        Operand b;
    } ReadResp;

    // Range is head inclusive, tail exclusive, and may wrap
    function automatic logic shouldFlush(RecoveryInfo rec, ActiveListPtr ptr);
        logic inRange;
        if (rec.head <= rec.tail) begin
            inRange = (ptr >= rec.head) && (ptr < rec.tail);
        end else begin
            inRange = (ptr >= rec.head) || (ptr < rec.tail);
        end
        return rec.flushAll || (rec.flushRange && inRange);
    endfunction

endpackage

/* rtl/PhysRegFile.sv */
// ==================================================
// Physical register file with per-register ready
// bits. One combinational read pair, one allocate
// port and one writeback port.
// ==================================================

`timescale 1ns/1ns

`include "memRr_params.svh"

module PhysRegFile import MemRrPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  ReadReq  rdReq,
    output ReadResp rdResp,
    input  logic    allocValid,
    input  PRegNum  allocReg,
    input  logic    wbValid,
    input  PRegNum  wbReg,
    input  DataWord wbData
);

    DataWord                    regData [`MEMRR_NUM_PREG];
    logic [`MEMRR_NUM_PREG-1:0] regReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MEMRR_NUM_PREG; i++) begin
                regData[i] <= '0;
            end
            regReady <= '1;
        end else begin
            if (allocValid) begin
                regReady[allocReg] <= 1'b0;
            end
            // Writeback is last so it wins over allocate
            if (wbValid) begin
                regData[wbReg]  <= wbData;
                regReady[wbReg] <= 1'b1;
            end
        end
    end

    // Reads see the state before this edge's writes
    always_comb begin
        rdResp.a.data  = regData[rdReq.srcA];
        rdResp.a.ready = regReady[rdReq.srcA];
        rdResp.b.data  = regData[rdReq.srcB];
        rdResp.b.ready = regReady[rdReq.srcB];
    end

endmodule

/* rtl/RegReadArbiter.sv */
// ==================================================
// Two-way round-robin arbiter for the shared read
// pair. Grants one lane per cycle and steers the
// winning request onto the register file port.
// ==================================================

`timescale 1ns/1ns

module RegReadArbiter import MemRrPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  ReadReq loadReq,
    input  ReadReq storeReq,
    output logic   loadGrant,
    output logic   storeGrant,
    output ReadReq portReq
);

    // High when the store lane won the last contested cycle
    logic lastStore;
    logic contested;

    assign contested = loadReq.valid && storeReq.valid;

    always_comb begin
        loadGrant  = loadReq.valid && (!storeReq.valid || lastStore);
        storeGrant = storeReq.valid && (!loadReq.valid || !lastStore);
    end

    // Idle cycles fall through to the load request, whose valid is low
    assign portReq = storeGrant ? storeReq : loadReq;

    always_ff @(posedge clk) begin
        if (rst) begin
            // Load lane goes first after reset
            lastStore <= 1'b1;
        end else if (contested) begin
            lastStore <= !lastStore;
        end
    end

endmodule

/* rtl/MemRegReadStage.sv */
// ==================================================
// One register-read lane. Holds an issued memory op
// until it wins the read port, then presents the op
// with its resolved operands. Payload type is set
// per lane by the PayloadT parameter.
// ==================================================

`timescale 1ns/1ns

module MemRegReadStage import MemRrPkg::*; #(
    parameter type PayloadT = LoadPayload
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        backEndStall,
    input  RecoveryInfo recovery,

    input  logic        issueValid,
    input  MemOpCommon  issueOp,
    input  PayloadT     issuePayload,
    output logic        issueStall,

    output ReadReq      readReq,
    input  logic        readGrant,
    input  ReadResp     readResp,

    output logic        outValid,
    output MemOpCommon  outOp,
    output PayloadT     outPayload,
    output Operand      operandA,
    output Operand      operandB
);

    function automatic DataWord selectOperand(
        OperandType opType,
        DataWord    regVal,
        DataWord    immVal,
        DataWord    pcVal
    );
        case (opType)
            OotImm:  return immVal;
            OotPc:   return pcVal;
            default: return regVal;
        endcase
    endfunction

    // Stage register
    logic       opValid;
    MemOpCommon op;
    PayloadT    payload;

    logic heldFlush;
    logic incomingFlush;
    logic leave;
    logic slotFree;
    logic accept;

    always_comb begin
        heldFlush     = opValid && shouldFlush(recovery, op.alPtr);
        incomingFlush = shouldFlush(recovery, issueOp.alPtr);

        // Op leaves once it holds the port and nothing blocks it
        leave    = opValid && readGrant && !backEndStall && !heldFlush;
        slotFree = !opValid || leave || heldFlush;

        issueStall = backEndStall || !slotFree;
        accept     = issueValid && !issueStall;
    end

    assign readReq.valid = opValid && !backEndStall;
    assign readReq.srcA  = op.srcA;
    assign readReq.srcB  = op.srcB;

    always_ff @(posedge clk) begin
        if (rst) begin
            opValid <= 1'b0;
        end else if (accept) begin
            // An op arriving under a matching recovery is killed on entry
            opValid <= !incomingFlush;
        end else if (heldFlush || leave) begin
            opValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op      <= issueOp;
            payload <= issuePayload;
        end
    end

    // Output side
    assign outValid   = leave;
    assign outOp      = op;
    assign outPayload = payload;

    always_comb begin
        operandA.data  = selectOperand(op.typeA, readResp.a.data, op.imm, op.pc);
        operandA.ready = (op.typeA != OotReg) || readResp.a.ready;
        operandB.data  = selectOperand(op.typeB, readResp.b.data, op.imm, op.pc);
        operandB.ready = (op.typeB != OotReg) || readResp.b.ready;
    end

endmodule

/* rtl/MemRegReadTop.sv */
// ==================================================
// Register-read top level for the memory back end.
// Connects the load and store lanes, the read-port
// arbiter and the shared physical register file.
// ==================================================

`timescale 1ns/1ns

module MemRegReadTop import MemRrPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        backEndStall,
    input  RecoveryInfo recovery,

    // Load lane issue
    input  logic        loadIssueValid,
    input  MemOpCommon  loadIssueOp,
    input  LoadPayload  loadIssuePayload,
    output logic        loadIssueStall,

    // Store lane issue
    input  logic        storeIssueValid,
    input  MemOpCommon  storeIssueOp,
    input  StorePayload storeIssuePayload,
    output logic        storeIssueStall,

    // Register file writes
    input  logic        allocValid,
    input  PRegNum      allocReg,
    input  logic        wbValid,
    input  PRegNum      wbReg,
    input  DataWord     wbData,

    // Load lane out
    output logic        loadOutValid,
    output MemOpCommon  loadOutOp,
    output LoadPayload  loadOutPayload,
    output Operand      loadOperandA,
    output Operand      loadOperandB,

    // Store lane out
    output logic        storeOutValid,
    output MemOpCommon  storeOutOp,
    output StorePayload storeOutPayload,
    output Operand      storeOperandA,
    output Operand      storeOperandB
);

    ReadReq  loadReq;
    ReadReq  storeReq;
    ReadReq  portReq;
    ReadResp rdResp;
    logic    loadGrant;
    logic    storeGrant;

    MemRegReadStage #(.PayloadT(LoadPayload)) loadStage (
        .clk(clk), .rst(rst), .backEndStall(backEndStall), .recovery(recovery),
        .issueValid(loadIssueValid), .issueOp(loadIssueOp),
        .issuePayload(loadIssuePayload), .issueStall(loadIssueStall),
        .readReq(loadReq), .readGrant(loadGrant), .readResp(rdResp),
        .outValid(loadOutValid), .outOp(loadOutOp), .outPayload(loadOutPayload),
        .operandA(loadOperandA), .operandB(loadOperandB)
    );

    MemRegReadStage #(.PayloadT(StorePayload)) storeStage (
        .clk(clk), .rst(rst), .backEndStall(backEndStall), .recovery(recovery),
        .issueValid(storeIssueValid), .issueOp(storeIssueOp),
        .issuePayload(storeIssuePayload), .issueStall(storeIssueStall),
        .readReq(storeReq), .readGrant(storeGrant), .readResp(rdResp),
        .outValid(storeOutValid), .outOp(storeOutOp), .outPayload(storeOutPayload),
        .operandA(storeOperandA), .operandB(storeOperandB)
    );

    RegReadArbiter arbiter (
        .clk(clk), .rst(rst),
        .loadReq(loadReq), .storeReq(storeReq),
        .loadGrant(loadGrant), .storeGrant(storeGrant),
        .portReq(portReq)
    );

    PhysRegFile regFile (
        .clk(clk), .rst(rst),
        .rdReq(portReq), .rdResp(rdResp),
        .allocValid(allocValid), .allocReg(allocReg),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
    );

endmodule

/* bench/MemRegReadTb_sva.sv */
// ==================================================
// Concurrent checks bound into the read-port
// arbiter and into each register-read lane.
// Unused inputs are tied low at the bind site.
// ==================================================

`timescale 1ns/1ns

module MemRegReadTb_sva (
    input logic clk,
    input logic rst,
    input logic reqA,
    input logic reqB,
    input logic grantA,
    input logic grantB,
    input logic outValid,
    input logic stall
);

    // Only one lane may own the read pair
    assert property (@(posedge clk) disable iff (rst) !(grantA && grantB))
        else $error("Both read grants are high in the same cycle");

    assert property (@(posedge clk) disable iff (rst) grantA |-> reqA)
        else $error("Grant A given without a request");

    assert property (@(posedge clk) disable iff (rst) grantB |-> reqB)
        else $error("Grant B given without a request");

    // Reset clears the stage register, so nothing leaves right after it
    assert property (@(posedge clk) rst |=> !outValid)
        else $error("Output valid seen after a reset edge");

    assert property (@(posedge clk) disable iff (rst) stall |-> !outValid)
        else $error("Output valid seen while the back end is stalled");

endmodule

bind RegReadArbiter MemRegReadTb_sva arbiterChecks (
    .clk(clk), .rst(rst),
    .reqA(loadReq.valid), .reqB(storeReq.valid),
    .grantA(loadGrant), .grantB(storeGrant),
    .outValid(1'b0), .stall(1'b0)
);

bind MemRegReadStage MemRegReadTb_sva stageChecks (
    .clk(clk), .rst(rst),
    .reqA(readReq.valid), .reqB(1'b0),
    .grantA(readGrant), .grantB(1'b0),
    .outValid(outValid), .stall(backEndStall)
);

/* bench/MemRegReadTb.sv */
// ==================================================
// Testbench for the memory register-read block.
// Drives seeded random issue, write, stall and flush
// traffic and checks every lane output against a
// reference model of lanes, arbiter and registers.
// ==================================================

`timescale 1ns/1ns

`include "memRr_params.svh"

module MemRegReadTb import MemRrPkg::*; ();

    localparam int RANDOM_CYCLES = 4000;
    localparam int DRAIN_LIMIT   = 50;
    localparam int DRIVE_DELAY   = 2;

    logic        clk;
    logic        rst;
    logic        backEndStall;
    RecoveryInfo recovery;
    logic        loadIssueValid;
    MemOpCommon  loadIssueOp;
    LoadPayload  loadIssuePayload;
    logic        loadIssueStall;
    logic        storeIssueValid;
    MemOpCommon  storeIssueOp;
    StorePayload storeIssuePayload;
    logic        storeIssueStall;
    logic        allocValid;
    PRegNum      allocReg;
    logic        wbValid;
    PRegNum      wbReg;
    DataWord     wbData;
    logic        loadOutValid;
    MemOpCommon  loadOutOp;
    LoadPayload  loadOutPayload;
    Operand      loadOperandA;
    Operand      loadOperandB;
    logic        storeOutValid;
    MemOpCommon  storeOutOp;
    StorePayload storeOutPayload;
    Operand      storeOperandA;
    Operand      storeOperandB;

    // Reference model state
    DataWord     modelData  [`MEMRR_NUM_PREG];
    logic        modelReady [`MEMRR_NUM_PREG];
    logic        modelLastStore;
    MemOpCommon  loadQ[$];
    LoadPayload  loadPayQ[$];
    MemOpCommon  storeQ[$];
    StorePayload storePayQ[$];
    logic [3:0]  loadTag;
    logic [3:0]  storeTag;
    int          loadDone;
    int          storeDone;
    int          waitCycles;

    MemRegReadTop UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic checkVal(input logic [127:0] got, input logic [127:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Circular window from head up to but not including tail
    function automatic logic flushMatch(RecoveryInfo rec, ActiveListPtr ptr);
        ActiveListPtr offset;
        ActiveListPtr span;
        offset = ptr - rec.head;
        span   = rec.tail - rec.head;
        return rec.flushAll || (rec.flushRange && (offset < span));
    endfunction

    function automatic Operand expectOperand(OperandType t, PRegNum src,
                                             DataWord imm, DataWord pc);
        Operand o;
        if (t == OotImm) begin
            o.data  = imm;
            o.ready = 1'b1;
        end else if (t == OotPc) begin
            o.data  = pc;
            o.ready = 1'b1;
        end else begin
            o.data  = modelData[src];
            o.ready = modelReady[src];
        end
        return o;
    endfunction

    function automatic MemOpCommon randomOp(logic [3:0] tag);
        MemOpCommon op;
        op.srcA  = 5'($urandom);
        op.srcB  = 5'($urandom);
        op.typeA = OperandType'(2'($urandom % 3));
        op.typeB = OperandType'(2'($urandom % 3));
        op.imm   = $urandom;
        op.pc    = $urandom;
        op.alPtr = 5'($urandom);
        op.tag   = tag;
        return op;
    endfunction

    task automatic checkLeaving(input string lane, input MemOpCommon got,
                                input MemOpCommon exp, input Operand gotA,
                                input Operand gotB);
        checkVal(128'(got), 128'(exp), {lane, " op"});
        checkVal(128'(gotA), 128'(expectOperand(exp.typeA, exp.srcA, exp.imm, exp.pc)),
                 {lane, " operand A"});
        checkVal(128'(gotB), 128'(expectOperand(exp.typeB, exp.srcB, exp.imm, exp.pc)),
                 {lane, " operand B"});
    endtask

    task automatic driveRandom();
        int roll;
        loadIssueValid    = ($urandom % 100) < 60;
        loadIssueOp       = randomOp(loadTag);
        loadIssuePayload  = LoadPayload'(3'($urandom));
        storeIssueValid   = ($urandom % 100) < 60;
        storeIssueOp      = randomOp(storeTag);
        storeIssuePayload = StorePayload'(6'($urandom));
        backEndStall      = ($urandom % 100) < 8;
        recovery          = '0;
        roll              = int'($urandom % 100);
        if (roll < 3) begin
            recovery.flushAll = 1'b1;
        end else if (roll < 10) begin
            recovery.flushRange = 1'b1;
            recovery.head       = 5'($urandom);
            recovery.tail       = 5'($urandom);
        end
        allocValid = ($urandom % 100) < 25;
        allocReg   = 5'($urandom);
        wbValid    = ($urandom % 100) < 30;
        wbReg      = 5'($urandom);
        wbData     = $urandom;
    endtask

    task automatic driveIdle();
        loadIssueValid  = 1'b0;
        storeIssueValid = 1'b0;
        backEndStall    = 1'b0;
        recovery        = '0;
        allocValid      = 1'b0;
        wbValid         = 1'b0;
    endtask

    // Checks outputs between edges and then applies the coming edge to the model
    task automatic evaluateCycle();
        logic loadHeld, storeHeld, loadFl, storeFl;
        logic loadReq, storeReq, loadGrant, storeGrant;
        logic loadLeave, storeLeave, loadStallExp, storeStallExp;
        loadHeld  = loadQ.size() != 0;
        storeHeld = storeQ.size() != 0;
        loadFl    = loadHeld && flushMatch(recovery, loadQ[0].alPtr);
        storeFl   = storeHeld && flushMatch(recovery, storeQ[0].alPtr);
        loadReq   = loadHeld && !backEndStall;
        storeReq  = storeHeld && !backEndStall;
        if (loadReq && storeReq) begin
            loadGrant  = modelLastStore;
            storeGrant = !modelLastStore;
            modelLastStore = !modelLastStore;
        end else begin
            loadGrant  = loadReq;
            storeGrant = storeReq;
        end
        loadLeave  = loadGrant && !loadFl;
        storeLeave = storeGrant && !storeFl;
        checkVal(128'(loadOutValid), 128'(loadLeave), "load outValid");
        checkVal(128'(storeOutValid), 128'(storeLeave), "store outValid");
        if (loadLeave) begin
            checkLeaving("load", loadOutOp, loadQ[0], loadOperandA, loadOperandB);
            checkVal(128'(loadOutPayload), 128'(loadPayQ[0]), "load payload");
            loadDone++;
        end
        if (storeLeave) begin
            checkLeaving("store", storeOutOp, storeQ[0], storeOperandA, storeOperandB);
            checkVal(128'(storeOutPayload), 128'(storePayQ[0]), "store payload");
            storeDone++;
        end
        if (loadLeave || loadFl) begin
            void'(loadQ.pop_front());
            void'(loadPayQ.pop_front());
        end
        if (storeLeave || storeFl) begin
            void'(storeQ.pop_front());
            void'(storePayQ.pop_front());
        end

        loadStallExp  = backEndStall || (loadHeld && !loadLeave && !loadFl);
        storeStallExp = backEndStall || (storeHeld && !storeLeave && !storeFl);
        checkVal(128'(loadIssueStall), 128'(loadStallExp), "load issueStall");
        checkVal(128'(storeIssueStall), 128'(storeStallExp), "store issueStall");
        if (loadIssueValid && !loadStallExp) begin
            loadTag++;
            if (!flushMatch(recovery, loadIssueOp.alPtr)) begin
                loadQ.push_back(loadIssueOp);
                loadPayQ.push_back(loadIssuePayload);
            end
        end
        if (storeIssueValid && !storeStallExp) begin
            storeTag++;
            if (!flushMatch(recovery, storeIssueOp.alPtr)) begin
                storeQ.push_back(storeIssueOp);
                storePayQ.push_back(storeIssuePayload);
            end
        end

        // Writeback after allocate, so it wins on the same register
        if (allocValid) begin
            modelReady[allocReg] = 1'b0;
        end
        if (wbValid) begin
            modelData[wbReg]  = wbData;
            modelReady[wbReg] = 1'b1;
        end
    endtask

    initial begin
        rst               = 1'b1;
        backEndStall      = 1'b0;
        recovery          = '0;
        loadIssueValid    = 1'b0;
        loadIssueOp       = '0;
        loadIssuePayload  = '0;
        storeIssueValid   = 1'b0;
        storeIssueOp      = '0;
        storeIssuePayload = '0;
        allocValid        = 1'b0;
        allocReg          = '0;
        wbValid           = 1'b0;
        wbReg             = '0;
        wbData            = '0;
        loadDone          = 0;
        storeDone         = 0;
        loadTag           = '0;
        storeTag          = '0;
        modelLastStore    = 1'b1;
        for (int i = 0; i < `MEMRR_NUM_PREG; i++) begin
            modelData[i]  = '0;
            modelReady[i] = 1'b1;
        end
        void'($urandom(32'he8cb_de15));

        repeat (3) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            checkVal(128'(loadOutValid), 128'(1'b0), "load outValid in reset");
            checkVal(128'(storeOutValid), 128'(1'b0), "store outValid in reset");
        end
        rst = 1'b0;

        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            driveRandom();
            @(negedge clk);
            evaluateCycle();
            @(posedge clk);
            #(DRIVE_DELAY);
        end

        // Let held ops leave with no further traffic
        driveIdle();
        waitCycles = 0;
        while ((loadQ.size() != 0) || (storeQ.size() != 0)) begin
            if (waitCycles >= DRAIN_LIMIT) begin
                $display("Timeout: lanes still hold ops after %0d idle cycles", DRAIN_LIMIT);
                $display("TEST RESULT: FAIL");
                $fatal(1, "Lanes did not drain");
            end
            @(negedge clk);
            evaluateCycle();
            @(posedge clk);
            #(DRIVE_DELAY);
            waitCycles++;
        end

        $display("Checked %0d load ops and %0d store ops", loadDone, storeDone);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* all.f */
+incdir+rtl
rtl/MemRrPkg.sv
rtl/PhysRegFile.sv
rtl/RegReadArbiter.sv
rtl/MemRegReadStage.sv
rtl/MemRegReadTop.sv
bench/MemRegReadTb_sva.sv
bench/MemRegReadTb.sv

/* run.sh */
#!/bin/sh
# Compile the register-read block and its testbench with Verilator, then run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module MemRegReadTb -f all.f

out=$(./obj_dir/VMemRegReadTb 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF "TEST RESULT: PASS"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
